//--- design/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// datapath widths
`define XLEN       32
`define REG_ADDR_W 5
`define RESET_PC   32'h0000_0000

// rv32i base opcodes
`define OP_RTYPE  7'b0110011
`define OP_ITYPE  7'b0010011
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_BRANCH 7'b1100011
`define OP_JAL    7'b1101111
`define OP_JALR   7'b1100111
`define OP_LUI    7'b0110111
`define OP_AUIPC  7'b0010111
`define OP_SYSTEM 7'b1110011

`endif

//--- design/rv_pkg.sv
`include "rv_defs.svh"

package rv_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_t;

    // writeback value source
    typedef enum logic [1:0] {
        RES_ALU,
        RES_MEM,
        RES_PC4
    } result_src_t;

    typedef struct packed {
        alu_op_t     alu_op;
        logic        b_is_imm;
        logic        a_is_pc;
        logic        reg_write;
        logic        mem_read;
        logic        mem_write;
        logic        branch;
        logic        jump;
        logic        jalr;
        logic [2:0]  funct3;
        result_src_t result_src;
        logic        ebreak;
    } ctrl_t;

    // ------------------------------------------------------------------
    // stage payloads
    // ------------------------------------------------------------------
    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] instr;
    } if_id_t;

    typedef struct packed {
        ctrl_t                  ctrl;
        logic [`XLEN-1:0]       pc;
        logic [`XLEN-1:0]       rs1_val;
        logic [`XLEN-1:0]       rs2_val;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       imm;
    } id_ex_t;

    typedef struct packed {
        ctrl_t                  ctrl;
        logic [`XLEN-1:0]       pc;
        logic [`XLEN-1:0]       result;
        logic [`XLEN-1:0]       store_data;
        logic [`REG_ADDR_W-1:0] rd;
    } ex_mem_t;

    typedef struct packed {
        ctrl_t                  ctrl;
        logic [`XLEN-1:0]       pc;
        logic [`XLEN-1:0]       result;
        logic [`XLEN-1:0]       load_data;
        logic [`REG_ADDR_W-1:0] rd;
    } mem_wb_t;

endpackage

//--- design/wb_bus_if.sv
`timescale 1ns/10ps
`include "rv_defs.svh"

// late-stage results seen by the forwarding logic
interface wb_bus_if;
    logic [`REG_ADDR_W-1:0] mem_rd;
    logic                   mem_reg_write;
    logic [`XLEN-1:0]       mem_result;
    logic [`REG_ADDR_W-1:0] wb_rd;
    logic                   wb_reg_write;
    logic [`XLEN-1:0]       wb_result;

    modport source (
        output mem_rd, mem_reg_write, mem_result,
        output wb_rd, wb_reg_write, wb_result
    );

    modport sink (
        input mem_rd, mem_reg_write, mem_result,
        input wb_rd, wb_reg_write, wb_result
    );
endinterface

//--- design/stage_reg.sv
`timescale 1ns/10ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     hold,
    input  logic     flush,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);
    // flush wins over hold
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            out_valid <= 1'b0;
        else if (flush)
            out_valid <= 1'b0;
        else if (!hold)
            out_valid <= in_valid;
    end

    always_ff @(posedge clk) begin
        if (!hold)
            out_data <= in_data;
    end
endmodule

//--- design/rv_decoder.sv
`timescale 1ns/10ps
`include "rv_defs.svh"

module rv_decoder import rv_pkg::*; (
    input  logic [`XLEN-1:0]       instr,
    output ctrl_t                  ctrl,
    output logic [`REG_ADDR_W-1:0] rs1,
    output logic [`REG_ADDR_W-1:0] rs2,
    output logic [`REG_ADDR_W-1:0] rd,
    output logic [`XLEN-1:0]       imm
);
    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic             alt;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_j;
    alu_op_t          arith_op;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign alt    = instr[30];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // shared by reg-reg and reg-imm forms
    always_comb begin
        case (funct3)
            3'b000: arith_op = ALU_ADD;
            3'b001: arith_op = ALU_SLL;
            3'b010: arith_op = ALU_SLT;
            3'b011: arith_op = ALU_SLTU;
            3'b100: arith_op = ALU_XOR;
            3'b101: arith_op = alt ? ALU_SRA : ALU_SRL;
            3'b110: arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    end

    always_comb begin
        ctrl = '0;
        imm  = imm_i;
        rs1  = instr[19:15];
        rs2  = '0;
        rd   = instr[11:7];
        case (opcode)
            `OP_RTYPE: begin
                ctrl.alu_op    = (funct3 == 3'b000 && alt) ? ALU_SUB : arith_op;
                ctrl.reg_write = 1'b1;
                rs2            = instr[24:20];
            end
            `OP_ITYPE: begin
                ctrl.alu_op    = arith_op;
                ctrl.b_is_imm  = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            `OP_LOAD: begin
                ctrl.b_is_imm   = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.reg_write  = 1'b1;
                ctrl.result_src = RES_MEM;
            end
            `OP_STORE: begin
                ctrl.b_is_imm  = 1'b1;
                ctrl.mem_write = 1'b1;
                imm            = imm_s;
                rs2            = instr[24:20];
            end
            `OP_BRANCH: begin
                // beq/bne on zero, the rest on the compare bit
                case (funct3[2:1])
                    2'b10: ctrl.alu_op = ALU_SLT;
                    2'b11: ctrl.alu_op = ALU_SLTU;
                    default: ctrl.alu_op = ALU_SUB;
                endcase
                ctrl.branch = 1'b1;
                ctrl.funct3 = funct3;
                imm         = imm_b;
                rs2         = instr[24:20];
            end
            `OP_JAL: begin
                ctrl.jump       = 1'b1;
                ctrl.reg_write  = 1'b1;
                ctrl.result_src = RES_PC4;
                imm             = imm_j;
                rs1             = '0;
            end
            `OP_JALR: begin
                ctrl.jump       = 1'b1;
                ctrl.jalr       = 1'b1;
                ctrl.reg_write  = 1'b1;
                ctrl.result_src = RES_PC4;
            end
            `OP_LUI: begin
                ctrl.alu_op    = ALU_PASS_B;
                ctrl.b_is_imm  = 1'b1;
                ctrl.reg_write = 1'b1;
                imm            = imm_u;
                rs1            = '0;
            end
            `OP_AUIPC: begin
                ctrl.a_is_pc   = 1'b1;
                ctrl.b_is_imm  = 1'b1;
                ctrl.reg_write = 1'b1;
                imm            = imm_u;
                rs1            = '0;
            end
            `OP_SYSTEM: begin
                ctrl.ebreak = (instr[31:7] == {12'h001, 13'b0});
                rs1         = '0;
            end
            default: begin
                rs1 = '0;
            end
        endcase
    end
endmodule

//--- design/reg_file.sv
`timescale 1ns/10ps
`include "rv_defs.svh"

module reg_file (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`REG_ADDR_W-1:0] waddr,
    input  logic [`XLEN-1:0]       wdata,
    input  logic                   wen,
    input  logic [`REG_ADDR_W-1:0] raddr1,
    input  logic [`REG_ADDR_W-1:0] raddr2,
    output logic [`XLEN-1:0]       rdata1,
    output logic [`XLEN-1:0]       rdata2
);
    logic [`XLEN-1:0] regs [1:31];

    // x0 reads zero and a same-cycle write passes through
    function automatic logic [`XLEN-1:0] read_port(input logic [`REG_ADDR_W-1:0] addr);
        if (addr == '0)
            return '0;
        else if (wen && addr == waddr)
            return wdata;
        else
            return regs[addr];
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    always_comb begin
        rdata1 = read_port(raddr1);
        rdata2 = read_port(raddr2);
    end
endmodule

//--- design/rv_alu.sv
`timescale 1ns/10ps
`include "rv_defs.svh"

module rv_alu import rv_pkg::*; (
    input  alu_op_t          op,
    input  logic [`XLEN-1:0] a,
    input  logic [`XLEN-1:0] b,
    output logic [`XLEN-1:0] y,
    output logic             zero
);
    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ALU_ADD:    y = a + b;
            ALU_SUB:    y = a - b;
            ALU_SLL:    y = a << shamt;
            ALU_SLT:    y = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU:   y = {{(`XLEN-1){1'b0}}, a < b};
            ALU_XOR:    y = a ^ b;
            ALU_SRL:    y = a >> shamt;
            ALU_SRA:    y = $signed(a) >>> shamt;
            ALU_OR:     y = a | b;
            ALU_AND:    y = a & b;
            ALU_PASS_B: y = b;
            default:    y = '0;
        endcase
    end

    // beq/bne look at this
    assign zero = (y == '0);
endmodule

//--- design/branch_unit.sv
`timescale 1ns/10ps
`include "rv_defs.svh"

module branch_unit import rv_pkg::*; (
    input  ctrl_t            ctrl,
    input  logic             valid,
    input  logic [`XLEN-1:0] pc,
    input  logic [`XLEN-1:0] imm,
    input  logic [`XLEN-1:0] rs1_val,
    input  logic [`XLEN-1:0] alu_y,
    input  logic             alu_zero,
    output logic             redirect,
    output logic [`XLEN-1:0] target
);
    logic taken;

    // funct3 bit 0 inverts the sense
    always_comb begin
        case (ctrl.funct3[2:1])
            2'b00:   taken = alu_zero ^ ctrl.funct3[0];
            2'b10,
            2'b11:   taken = alu_y[0] ^ ctrl.funct3[0];
            default: taken = 1'b0;
        endcase
    end

    assign redirect = valid && (ctrl.jump || (ctrl.branch && taken));
    assign target   = ctrl.jalr ? ((rs1_val + imm) & ~`XLEN'd1) : pc + imm;
endmodule

//--- design/hazard_unit.sv
`timescale 1ns/10ps
`include "rv_defs.svh"

module hazard_unit (
    wb_bus_if.sink                 bus,
    input  logic [`REG_ADDR_W-1:0] ex_rs1,
    input  logic [`REG_ADDR_W-1:0] ex_rs2,
    input  logic [`XLEN-1:0]       ex_rs1_val,
    input  logic [`XLEN-1:0]       ex_rs2_val,
    input  logic                   ex_mem_read,
    input  logic [`REG_ADDR_W-1:0] ex_rd,
    input  logic                   ex_valid,
    input  logic [`REG_ADDR_W-1:0] id_rs1,
    input  logic [`REG_ADDR_W-1:0] id_rs2,
    output logic [`XLEN-1:0]       fwd_rs1,
    output logic [`XLEN-1:0]       fwd_rs2,
    output logic                   load_stall
);
    // memory stage is younger, so it wins
    function automatic logic [`XLEN-1:0] pick(
        input logic [`REG_ADDR_W-1:0] rs,
        input logic [`XLEN-1:0]       reg_val
    );
        if (rs != '0 && bus.mem_reg_write && bus.mem_rd == rs)
            return bus.mem_result;
        else if (rs != '0 && bus.wb_reg_write && bus.wb_rd == rs)
            return bus.wb_result;
        else
            return reg_val;
    endfunction

    always_comb begin
        fwd_rs1 = pick(ex_rs1, ex_rs1_val);
        fwd_rs2 = pick(ex_rs2, ex_rs2_val);
    end

    // load data only exists one stage later
    assign load_stall = ex_valid && ex_mem_read && ex_rd != '0
                        && (ex_rd == id_rs1 || ex_rd == id_rs2);
endmodule

//--- design/rv_core.sv
`timescale 1ns/10ps
`include "rv_defs.svh"

module rv_core import rv_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic [`XLEN-1:0] imem_data,
    input  logic [`XLEN-1:0] dmem_rdata,
    output logic [`XLEN-1:0] imem_addr,
    output logic [`XLEN-1:0] dmem_addr,
    output logic [`XLEN-1:0] dmem_wdata,
    output logic             dmem_wen,
    output logic             dmem_ren,
    output logic             retire_valid,
    output logic [`XLEN-1:0] retire_pc,
    output logic             ebreak
);
    logic [`XLEN-1:0]       pc;
    logic                   redirect;
    logic                   load_stall;
    logic [`XLEN-1:0]       target;
    if_id_t                 fd_in, fd_q;
    id_ex_t                 de_in, de_q;
    ex_mem_t                em_in, em_q;
    mem_wb_t                mw_in, mw_q;
    logic                   fd_valid, de_valid, em_valid, mw_valid;
    ctrl_t                  dec_ctrl;
    logic [`REG_ADDR_W-1:0] dec_rs1, dec_rs2, dec_rd;
    logic [`XLEN-1:0]       dec_imm, rf_rd1, rf_rd2;
    logic [`XLEN-1:0]       fwd_rs1, fwd_rs2, alu_a, alu_b, alu_y, ex_result;
    logic                   alu_zero;
    logic [`XLEN-1:0]       wb_value;
    logic                   wb_wen;

    wb_bus_if fwd_bus ();

    // ------------------------------------------------------------------
    // fetch
    // ------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            pc <= `RESET_PC;
        else if (redirect)
            pc <= target;
        else if (!load_stall)
            pc <= pc + `XLEN'd4;
    end

    assign imem_addr = pc;
    assign fd_in     = '{pc: pc, instr: imem_data};

    stage_reg #(.payload_t(if_id_t)) u_fd (
        .clk(clk), .rst(rst), .hold(load_stall), .flush(redirect),
        .in_valid(1'b1), .in_data(fd_in), .out_valid(fd_valid), .out_data(fd_q)
    );

    // ------------------------------------------------------------------
    // decode
    // ------------------------------------------------------------------
    rv_decoder u_dec (
        .instr(fd_q.instr), .ctrl(dec_ctrl), .rs1(dec_rs1), .rs2(dec_rs2),
        .rd(dec_rd), .imm(dec_imm)
    );

    reg_file u_rf (
        .clk(clk), .rst(rst), .waddr(mw_q.rd), .wdata(wb_value), .wen(wb_wen),
        .raddr1(dec_rs1), .raddr2(dec_rs2), .rdata1(rf_rd1), .rdata2(rf_rd2)
    );

    assign de_in = '{ctrl: dec_ctrl, pc: fd_q.pc, rs1_val: rf_rd1, rs2_val: rf_rd2,
                     rs1: dec_rs1, rs2: dec_rs2, rd: dec_rd, imm: dec_imm};

    // a stall drops a bubble into execute
    stage_reg #(.payload_t(id_ex_t)) u_de (
        .clk(clk), .rst(rst), .hold(1'b0), .flush(redirect || load_stall),
        .in_valid(fd_valid), .in_data(de_in), .out_valid(de_valid), .out_data(de_q)
    );

    // ------------------------------------------------------------------
    // execute
    // ------------------------------------------------------------------
    hazard_unit u_haz (
        .bus(fwd_bus.sink), .ex_rs1(de_q.rs1), .ex_rs2(de_q.rs2),
        .ex_rs1_val(de_q.rs1_val), .ex_rs2_val(de_q.rs2_val),
        .ex_mem_read(de_q.ctrl.mem_read), .ex_rd(de_q.rd), .ex_valid(de_valid),
        .id_rs1(dec_rs1), .id_rs2(dec_rs2), .fwd_rs1(fwd_rs1), .fwd_rs2(fwd_rs2),
        .load_stall(load_stall)
    );

    assign alu_a = de_q.ctrl.a_is_pc ? de_q.pc : fwd_rs1;
    assign alu_b = de_q.ctrl.b_is_imm ? de_q.imm : fwd_rs2;

    rv_alu u_alu (
        .op(de_q.ctrl.alu_op), .a(alu_a), .b(alu_b), .y(alu_y), .zero(alu_zero)
    );

    branch_unit u_br (
        .ctrl(de_q.ctrl), .valid(de_valid), .pc(de_q.pc), .imm(de_q.imm),
        .rs1_val(fwd_rs1), .alu_y(alu_y), .alu_zero(alu_zero),
        .redirect(redirect), .target(target)
    );

    // link address for jal/jalr
    assign ex_result = (de_q.ctrl.result_src == RES_PC4) ? de_q.pc + `XLEN'd4 : alu_y;
    assign em_in     = '{ctrl: de_q.ctrl, pc: de_q.pc, result: ex_result,
                         store_data: fwd_rs2, rd: de_q.rd};

    stage_reg #(.payload_t(ex_mem_t)) u_em (
        .clk(clk), .rst(rst), .hold(1'b0), .flush(1'b0),
        .in_valid(de_valid), .in_data(em_in), .out_valid(em_valid), .out_data(em_q)
    );

    // ------------------------------------------------------------------
    // memory and writeback
    // ------------------------------------------------------------------
    assign dmem_addr  = em_q.result;
    assign dmem_wdata = em_q.store_data;
    assign dmem_wen   = em_valid && em_q.ctrl.mem_write;
    assign dmem_ren   = em_valid && em_q.ctrl.mem_read;
    assign mw_in      = '{ctrl: em_q.ctrl, pc: em_q.pc, result: em_q.result,
                          load_data: dmem_rdata, rd: em_q.rd};

    stage_reg #(.payload_t(mem_wb_t)) u_mw (
        .clk(clk), .rst(rst), .hold(1'b0), .flush(1'b0),
        .in_valid(em_valid), .in_data(mw_in), .out_valid(mw_valid), .out_data(mw_q)
    );

    assign wb_value = (mw_q.ctrl.result_src == RES_MEM) ? mw_q.load_data : mw_q.result;
    assign wb_wen   = mw_valid && mw_q.ctrl.reg_write;

    assign fwd_bus.mem_rd        = em_q.rd;
    assign fwd_bus.mem_reg_write = em_valid && em_q.ctrl.reg_write;
    assign fwd_bus.mem_result    = em_q.result;
    assign fwd_bus.wb_rd         = mw_q.rd;
    assign fwd_bus.wb_reg_write  = wb_wen;
    assign fwd_bus.wb_result     = wb_value;

    assign retire_valid = mw_valid;
    assign retire_pc    = mw_q.pc;
    assign ebreak       = mw_valid && mw_q.ctrl.ebreak;
endmodule

//--- verification/tb_rv_core.sv
`timescale 1ns/10ps
`include "rv_defs.svh"

module tb_rv_core;
    localparam int PROG_LEN   = 300;
    localparam int IMEM_WORDS = 512;
    localparam int DMEM_WORDS = 64;
    localparam int RST_CYCLES = 10;

    logic        clk;
    logic        rst;
    logic [31:0] imem_data;
    logic [31:0] dmem_rdata;
    logic [31:0] imem_addr;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic        dmem_wen;
    logic        dmem_ren;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic        ebreak;

    logic [31:0] imem [IMEM_WORDS];
    logic [31:0] dmem [DMEM_WORDS];
    logic [31:0] model_mem [DMEM_WORDS];
    logic [31:0] exp_pc [$];
    logic [31:0] exp_st_addr [$];
    logic [31:0] exp_st_data [$];
    logic [31:0] exp_ld_addr [$];

    int model_retires = 0;
    int model_stores  = 0;
    int retires       = 0;
    int stores        = 0;
    int retire_errs   = 0;
    int store_errs    = 0;
    int load_errs     = 0;
    int other_errs    = 0;
    bit finished      = 1'b0;
    bit timed_out     = 1'b0;

    rv_core DUT (
        .clk(clk), .rst(rst), .imem_data(imem_data), .dmem_rdata(dmem_rdata),
        .imem_addr(imem_addr), .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
        .dmem_wen(dmem_wen), .dmem_ren(dmem_ren), .retire_valid(retire_valid),
        .retire_pc(retire_pc), .ebreak(ebreak)
    );

    // both memories answer in the same cycle
    assign imem_data  = imem[imem_addr[10:2]];
    assign dmem_rdata = dmem_ren ? dmem[dmem_addr[7:2]] : 32'h0;

    always @(posedge clk) begin
        if (dmem_wen)
            dmem[dmem_addr[7:2]] <= dmem_wdata;
    end

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------------------------------------------
    // instruction encoding
    // ------------------------------------------------------------------
    function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3,
                                               input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `OP_RTYPE};
    endfunction

    function automatic logic [31:0] itype_word(input logic [11:0] imm, input logic [4:0] rs1,
                                               input logic [2:0] f3, input logic [4:0] rd,
                                               input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] store_word(input logic [11:0] imm, input logic [4:0] rs2,
                                               input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `OP_STORE};
    endfunction

    function automatic logic [31:0] branch_word(input logic [12:0] off, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `OP_BRANCH};
    endfunction

    function automatic logic [31:0] jal_word(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, `OP_JAL};
    endfunction

    // small pool keeps dependencies close together
    function automatic logic [4:0] pool_reg();
        return 5'(1 + $urandom % 6);
    endfunction

    function automatic logic [11:0] word_offset();
        return 12'(($urandom % DMEM_WORDS) * 4);
    endfunction

    task automatic fill_memories();
        for (int i = 0; i < IMEM_WORDS; i++)
            imem[i] = itype_word(12'(i), 5'd0, 3'b000, 5'd0, `OP_ITYPE);
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i]      = {8'(i), ~8'(i), 8'(i * 37), 8'h5a};
            model_mem[i] = dmem[i];
        end
    endtask

    task automatic gen_program();
        int          idx;
        int          kind;
        int          skip;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [6:0]  f7;
        idx = 0;
        while (idx < PROG_LEN - 1) begin
            kind = $urandom % 16;
            skip = 1 + $urandom % 3;
            rd   = pool_reg();
            f3   = 3'($urandom % 8);
            if (kind == 11 && idx < PROG_LEN - 2) begin
                // load with a consumer right behind it
                imem[idx] = itype_word(word_offset(), 5'd0, 3'b010, rd, `OP_LOAD);
                if ($urandom % 2 == 0)
                    imem[idx + 1] = rtype_word(7'h00, pool_reg(), rd, 3'b000, pool_reg());
                else
                    imem[idx + 1] = store_word(word_offset(), rd, 5'd0);
                idx += 2;
            end else if (kind == 12) begin
                imem[idx] = store_word(word_offset(), pool_reg(), 5'd0);
                idx++;
            end else if ((kind == 13 || kind == 14) && idx + skip + 1 <= PROG_LEN - 1) begin
                f3 = 3'($urandom % 6);
                if (f3 >= 3'd2)
                    f3 = f3 + 3'd2;
                imem[idx] = branch_word(13'((skip + 1) * 4), pool_reg(), pool_reg(), f3);
                idx++;
            end else if (kind == 15 && idx + skip + 1 <= PROG_LEN - 1) begin
                imem[idx] = jal_word(21'((skip + 1) * 4), ($urandom % 2 == 0) ? rd : 5'd0);
                idx++;
            end else if (kind == 9 || kind == 10) begin
                imem[idx] = {20'($urandom), rd, (kind == 9) ? `OP_LUI : `OP_AUIPC};
                idx++;
            end else if (kind >= 5 && kind <= 8) begin
                if (f3 == 3'b001)
                    imm = {7'h00, 5'($urandom)};
                else if (f3 == 3'b101)
                    imm = {($urandom % 2 == 0) ? 7'h20 : 7'h00, 5'($urandom)};
                else
                    imm = 12'($urandom);
                imem[idx] = itype_word(imm, pool_reg(), f3, rd, `OP_ITYPE);
                idx++;
            end else begin
                f7 = ((f3 == 3'b000 || f3 == 3'b101) && $urandom % 2 == 0) ? 7'h20 : 7'h00;
                imem[idx] = rtype_word(f7, pool_reg(), pool_reg(), f3, rd);
                idx++;
            end
        end
        imem[PROG_LEN - 1] = 32'h0010_0073;
    endtask

    // ------------------------------------------------------------------
    // instruction-set model
    // ------------------------------------------------------------------
    function automatic logic [31:0] arith(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic bit branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic run_model();
        logic [31:0] x [32];
        logic [31:0] pc;
        logic [31:0] next_pc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] addr;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_u;
        logic [31:0] imm_j;
        logic [2:0]  f3;
        bit          wr;
        bit          halt;
        int          steps;
        foreach (x[i])
            x[i] = 32'h0;
        pc    = `RESET_PC;
        halt  = 1'b0;
        steps = 0;
        while (!halt && steps < 2 * PROG_LEN) begin
            ins     = imem[pc[10:2]];
            f3      = ins[14:12];
            a       = x[ins[19:15]];
            b       = x[ins[24:20]];
            imm_i   = {{20{ins[31]}}, ins[31:20]};
            imm_s   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b   = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            imm_u   = {ins[31:12], 12'h000};
            imm_j   = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            next_pc = pc + 32'd4;
            res     = 32'h0;
            wr      = 1'b1;
            exp_pc.push_back(pc);
            case (ins[6:0])
                `OP_RTYPE: res = arith(f3, ins[30], a, b);
                `OP_ITYPE: res = arith(f3, f3 == 3'b101 && ins[30], a, imm_i);
                `OP_LOAD: begin
                    addr = a + imm_i;
                    res  = model_mem[addr[7:2]];
                    exp_ld_addr.push_back(addr);
                end
                `OP_STORE: begin
                    addr = a + imm_s;
                    wr   = 1'b0;
                    model_mem[addr[7:2]] = b;
                    exp_st_addr.push_back(addr);
                    exp_st_data.push_back(b);
                end
                `OP_BRANCH: begin
                    wr = 1'b0;
                    if (branch_taken(f3, a, b))
                        next_pc = pc + imm_b;
                end
                `OP_JAL: begin
                    res     = pc + 32'd4;
                    next_pc = pc + imm_j;
                end
                `OP_LUI:   res = imm_u;
                `OP_AUIPC: res = pc + imm_u;
                default: begin
                    wr   = 1'b0;
                    halt = (ins == 32'h0010_0073);
                end
            endcase
            if (wr && ins[11:7] != 5'd0)
                x[ins[11:7]] = res;
            pc = next_pc;
            steps++;
        end
    endtask

    // ------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------
    task automatic check_store();
        logic [31:0] ea;
        logic [31:0] ed;
        stores++;
        if (exp_st_addr.size() == 0) begin
            store_errs++;
            $display("store to %h seen after the model ran out of stores", dmem_addr);
        end else begin
            ea = exp_st_addr.pop_front();
            ed = exp_st_data.pop_front();
            if (dmem_addr != ea) begin
                store_errs++;
                $display("[FAIL] dmem_addr = %h, expected %h", dmem_addr, ea);
            end
            if (dmem_wdata != ed) begin
                store_errs++;
                $display("[FAIL] dmem_wdata = %h, expected %h (addr %h)", dmem_wdata, ed, ea);
            end
        end
    endtask

    task automatic check_load();
        logic [31:0] ea;
        if (exp_ld_addr.size() == 0) begin
            load_errs++;
            $display("load from %h seen after the model ran out of loads", dmem_addr);
        end else begin
            ea = exp_ld_addr.pop_front();
            if (dmem_addr != ea) begin
                load_errs++;
                $display("[FAIL] dmem_addr = %h, expected load address %h", dmem_addr, ea);
            end
        end
    endtask

    task automatic check_retire();
        logic [31:0] ep;
        retires++;
        if (exp_pc.size() == 0) begin
            retire_errs++;
            $display("instruction at %h retired after the model's program ended", retire_pc);
        end else begin
            ep = exp_pc.pop_front();
            if (retire_pc != ep) begin
                retire_errs++;
                $display("[FAIL] retire_pc = %h, expected %h", retire_pc, ep);
            end
        end
        if (ebreak) begin
            if (exp_pc.size() != 0 || exp_st_addr.size() != 0
                || exp_ld_addr.size() != 0) begin
                other_errs++;
                $display("ebreak retired with %0d instructions, %0d stores, %0d loads pending",
                         exp_pc.size(), exp_st_addr.size(), exp_ld_addr.size());
            end
            finished = 1'b1;
        end else if (exp_pc.size() == 0) begin
            other_errs++;
            $display("last instruction retired without ebreak being raised");
            finished = 1'b1;
        end
    endtask

    always @(negedge clk) begin
        if (rst) begin
            if (retire_valid || dmem_wen || dmem_ren || ebreak) begin
                other_errs++;
                $display("retire, store, load or ebreak active while reset is asserted");
            end
        end else if (!finished && !timed_out) begin
            if (dmem_wen)
                check_store();
            if (dmem_ren)
                check_load();
            if (retire_valid)
                check_retire();
            else if (ebreak) begin
                other_errs++;
                $display("ebreak raised with no instruction retiring");
            end
        end
    end

    // watchdog allows ten cycles per program instruction
    initial begin
        repeat (RST_CYCLES + 10 * PROG_LEN) @(posedge clk);
        if (!finished) begin
            other_errs++;
            $display("timeout, the program did not reach ebreak in %0d cycles", 10 * PROG_LEN);
            timed_out = 1'b1;
        end
    end

    initial begin
        rst = 1'b1;
        void'($urandom(32'hc87b));
        fill_memories();
        gen_program();
        run_model();
        model_retires = exp_pc.size();
        model_stores  = exp_st_addr.size();
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
        wait (finished || timed_out);
        if (retires != model_retires || stores != model_stores) begin
            other_errs++;
            $display("retire or store count differs from the model");
        end
        $display(
            "retired %0d/%0d, stores %0d/%0d, errors retire %0d store %0d load %0d other %0d",
            retires, model_retires, stores, model_stores,
            retire_errs, store_errs, load_errs, other_errs);
        if (retire_errs + store_errs + load_errs + other_errs == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end
endmodule

//--- list.f
+incdir+design
design/rv_pkg.sv
design/wb_bus_if.sv
design/stage_reg.sv
design/rv_decoder.sv
design/reg_file.sv
design/rv_alu.sv
design/branch_unit.sv
design/hazard_unit.sv
design/rv_core.sv
verification/tb_rv_core.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the rv_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -Wno-fatal -f list.f --top-module tb_rv_core -o sim_tb_rv_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb_rv_core > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" "$log"; then
    exit 1
fi
if ! grep -q "Test passed" "$log"; then
    echo "no result line found in $log"
    exit 1
fi
exit 0
